// File: hw/chunk_loader.sv
//**************************************************************************
// Chunk loader
// Collects serial key and tag elements into the eight network lanes. The
// lanes that a chunk does not fill are marked as pads so they sort last.
// A one-cycle load_done comes with the completed lanes.
//**************************************************************************

module chunk_loader #(
    parameter int KEY_WIDTH = 16,
    parameter int TAG_WIDTH = 8
) (
    input  logic                              clock,
    input  logic                              rst_n,
    input  logic                              in_valid,
    input  logic [KEY_WIDTH-1:0]              in_key,
    input  logic [TAG_WIDTH-1:0]              in_tag,
    input  logic [sort_lane_pkg::COUNT_W-1:0] chunk_size,
    output logic                              lane_pad [sort_lane_pkg::LANES],
    output logic [KEY_WIDTH-1:0]              lane_key [sort_lane_pkg::LANES],
    output logic [TAG_WIDTH-1:0]              lane_tag [sort_lane_pkg::LANES],
    output logic [sort_lane_pkg::COUNT_W-1:0] chunk_count,
    output logic                              load_done
);

    localparam int CW = sort_lane_pkg::COUNT_W;

    logic [sort_lane_pkg::LANE_IDX_W-1:0] wr_idx;
    logic                                 last_elem;

    // The element being written closes the chunk
    assign last_elem = (CW'(wr_idx) == chunk_size - CW'(1));

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_idx    <= '0;
            load_done <= 1'b0;
        end else begin
            load_done <= 1'b0;
            if (in_valid) begin
                if (last_elem) begin
                    wr_idx    <= '0;
                    load_done <= 1'b1;
                end else begin
                    wr_idx <= wr_idx + 1'b1;
                end
            end
        end
    end

    // Each element lands in the lane selected by the write index
    always_ff @(posedge clock) begin
        if (in_valid) begin
            // A new chunk starts with every other lane padded
            if (wr_idx == '0) begin
                for (int i = 1; i < sort_lane_pkg::LANES; i++) begin
                    lane_pad[i] <= 1'b1;
                end
            end
            lane_pad[wr_idx] <= 1'b0;
            lane_key[wr_idx] <= in_key;
            lane_tag[wr_idx] <= in_tag;
            if (last_elem) begin
                chunk_count <= chunk_size;
            end
        end
    end

    a_chunk_size_legal: assert property (@(posedge clock) disable iff (!rst_n)
        in_valid |-> (chunk_size >= sort_ctrl_pkg::MIN_CHUNK &&
                      chunk_size <= sort_ctrl_pkg::MAX_CHUNK))
        else $error("chunk_size %0d out of range", chunk_size);

    // Downstream stages rely on one chunk size for all data in flight
    a_chunk_size_stable: assert property (@(posedge clock) disable iff (!rst_n)
        (wr_idx != '0) |-> $stable(chunk_size))
        else $error("chunk_size changed in the middle of a chunk");

endmodule

// File: hw/lane_counter.sv
//**************************************************************************
// Lane counter
// Index of the lane currently sent by the serializer. Clears to zero or
// steps by one and flags the last lane of the chunk.
//**************************************************************************

module lane_counter (
    input  logic                                 clock,
    input  logic                                 rst_n,
    input  logic                                 clear,
    input  logic                                 step,
    input  logic [sort_lane_pkg::COUNT_W-1:0]    limit,
    output logic [sort_lane_pkg::LANE_IDX_W-1:0] idx,
    output logic                                 at_last
);

    localparam int CW = sort_lane_pkg::COUNT_W;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            idx <= '0;
        end else if (clear) begin
            idx <= '0;
        end else if (step) begin
            idx <= idx + 1'b1;
        end
    end

    assign at_last = (CW'(idx) == limit - CW'(1));

    // The serializer must clear rather than step once the last lane is out
    a_no_overrun: assert property (@(posedge clock) disable iff (!rst_n)
        (step && !clear) |-> (CW'(idx) + CW'(1) < limit))
        else $error("lane counter stepped past limit %0d", limit);

endmodule

// File: hw/merge_network.sv
//**************************************************************************
// Merge network
// Pipelined Batcher odd-even merge sort over eight lanes. Nineteen
// compare-exchange elements are spread over six register stages. Entries
// are ordered on the pad bit and key together and the tag moves with its
// key. Count and valid ride along in a matching shift register.
//**************************************************************************

module merge_network #(
    parameter int KEY_WIDTH = 16,
    parameter int TAG_WIDTH = 8
) (
    input  logic                              clock,
    input  logic                              rst_n,
    input  logic                              in_pad [sort_lane_pkg::LANES],
    input  logic [KEY_WIDTH-1:0]              in_key [sort_lane_pkg::LANES],
    input  logic [TAG_WIDTH-1:0]              in_tag [sort_lane_pkg::LANES],
    input  logic [sort_lane_pkg::COUNT_W-1:0] in_count,
    input  logic                              in_valid,
    output logic                              out_pad [sort_lane_pkg::LANES],
    output logic [KEY_WIDTH-1:0]              out_key [sort_lane_pkg::LANES],
    output logic [TAG_WIDTH-1:0]              out_tag [sort_lane_pkg::LANES],
    output logic [sort_lane_pkg::COUNT_W-1:0] out_count,
    output logic                              out_valid
);

    localparam int LANES   = sort_lane_pkg::LANES;
    localparam int STAGES  = sort_lane_pkg::STAGES;
    localparam int CW      = sort_lane_pkg::COUNT_W;
    // Entry layout is pad bit, key, tag from the top down
    localparam int ENTRY_W = 1 + KEY_WIDTH + TAG_WIDTH;

    // Lane paired with a given lane in a given stage, or the lane itself
    // when it passes through that stage untouched
    function automatic int partner(input int stage, input int lane);
        int p;
        p = lane;
        case (stage)
            0: p = lane ^ 1;
            1: p = lane ^ 2;
            2: if (lane inside {1, 2, 5, 6}) p = lane ^ 3;
            3: p = lane ^ 4;
            4: if (lane inside {[2:5]}) p = lane ^ 6;
            default: if (lane inside {[1:6]}) p = (lane % 2 == 1) ? lane + 1 : lane - 1;
        endcase
        return p;
    endfunction

    logic [ENTRY_W-1:0] lane_in [LANES];
    logic [ENTRY_W-1:0] stage_q [STAGES][LANES];
    logic [STAGES-1:0]  valid_q;
    logic [CW-1:0]      count_q [STAGES];

    for (genvar i = 0; i < LANES; i++) begin : g_pack
        assign lane_in[i] = {in_pad[i], in_key[i], in_tag[i]};
    end

    for (genvar s = 0; s < STAGES; s++) begin : g_stage
        for (genvar i = 0; i < LANES; i++) begin : g_lane
            localparam int P = partner(s, i);

            logic [ENTRY_W-1:0] own;

            if (s == 0) begin : g_first
                assign own = lane_in[i];
            end else begin : g_next
                assign own = stage_q[s-1][i];
            end

            if (P == i) begin : g_pass
                always_ff @(posedge clock) begin
                    stage_q[s][i] <= own;
                end
            end else begin : g_pair
                logic [ENTRY_W-1:0] other;
                logic               keep;

                if (s == 0) begin : g_first
                    assign other = lane_in[P];
                end else begin : g_next
                    assign other = stage_q[s-1][P];
                end

                // The lower lane of a pair ends up with the smaller entry
                // and equal entries stay where they are
                if (i < P) begin : g_low
                    assign keep = !(own[ENTRY_W-1:TAG_WIDTH] > other[ENTRY_W-1:TAG_WIDTH]);
                end else begin : g_high
                    assign keep = !(other[ENTRY_W-1:TAG_WIDTH] > own[ENTRY_W-1:TAG_WIDTH]);
                end

                always_ff @(posedge clock) begin
                    stage_q[s][i] <= keep ? own : other;
                end
            end
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[STAGES-2:0], in_valid};
        end
    end

    always_ff @(posedge clock) begin
        count_q[0] <= in_count;
        for (int s = 1; s < STAGES; s++) begin
            count_q[s] <= count_q[s-1];
        end
    end

    for (genvar i = 0; i < LANES; i++) begin : g_unpack
        assign out_pad[i] = stage_q[STAGES-1][i][ENTRY_W-1];
        assign out_key[i] = stage_q[STAGES-1][i][TAG_WIDTH +: KEY_WIDTH];
        assign out_tag[i] = stage_q[STAGES-1][i][TAG_WIDTH-1:0];
    end

    assign out_count = count_q[STAGES-1];
    assign out_valid = valid_q[STAGES-1];

endmodule

// File: hw/out_serializer_fsm.sv
//**************************************************************************
// Output serializer
// Captures each sorted chunk into a hold buffer and streams its first
// chunk_count lanes out one per cycle, marking the final one. A new chunk
// arriving with the last lane is taken without a gap.
//**************************************************************************

module out_serializer_fsm #(
    parameter int KEY_WIDTH = 16,
    parameter int TAG_WIDTH = 8
) (
    input  logic                                 clock,
    input  logic                                 rst_n,
    input  logic [KEY_WIDTH-1:0]                 sorted_key [sort_lane_pkg::LANES],
    input  logic [TAG_WIDTH-1:0]                 sorted_tag [sort_lane_pkg::LANES],
    input  logic [sort_lane_pkg::COUNT_W-1:0]    sorted_count,
    input  logic                                 sorted_valid,
    input  logic [sort_lane_pkg::LANE_IDX_W-1:0] idx,
    input  logic                                 at_last,
    output logic                                 cnt_clear,
    output logic                                 cnt_step,
    output logic [sort_lane_pkg::COUNT_W-1:0]    cnt_limit,
    output logic                                 out_valid,
    output logic [KEY_WIDTH-1:0]                 out_key,
    output logic [TAG_WIDTH-1:0]                 out_tag,
    output logic                                 out_last
);

    sort_ctrl_pkg::ser_state_e state;

    logic [KEY_WIDTH-1:0]              hold_key [sort_lane_pkg::LANES];
    logic [TAG_WIDTH-1:0]              hold_tag [sort_lane_pkg::LANES];
    logic [sort_lane_pkg::COUNT_W-1:0] hold_count;
    logic                              streaming;
    logic                              load;

    assign streaming = (state == sort_ctrl_pkg::ser_stream);

    // A chunk is accepted when idle or on the last lane of the current one
    assign load = sorted_valid && (!streaming || at_last);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state      <= sort_ctrl_pkg::ser_idle;
            hold_count <= '0;
        end else begin
            if (load) begin
                state      <= sort_ctrl_pkg::ser_stream;
                hold_count <= sorted_count;
            end else if (streaming && at_last) begin
                state <= sort_ctrl_pkg::ser_idle;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            hold_key <= sorted_key;
            hold_tag <= sorted_tag;
        end
    end

    // Index sits at zero while idle so lane 0 is ready on entry to streaming
    assign cnt_clear = !streaming || at_last;
    assign cnt_step  = streaming && !at_last;
    assign cnt_limit = hold_count;

    assign out_valid = streaming;
    assign out_key   = hold_key[idx];
    assign out_tag   = hold_tag[idx];
    assign out_last  = streaming && at_last;

    // Chunks arrive no faster than they drain when chunk_size is held
    a_chunk_spacing: assert property (@(posedge clock) disable iff (!rst_n)
        (sorted_valid && streaming) |-> at_last)
        else $error("sorted chunk arrived while lane %0d was streaming", idx);

endmodule

// File: hw/serial_batcher_sorter.sv
//**************************************************************************
// Serial Batcher sorter
// Sorts a serial stream of key and tag elements in chunks of up to eight.
// Loader, merge network, lane counter and output serializer in a row.
//**************************************************************************

module serial_batcher_sorter #(
    parameter int KEY_WIDTH = 16,
    parameter int TAG_WIDTH = 8
) (
    input  logic                              clock,
    input  logic                              rst_n,
    input  logic [sort_lane_pkg::COUNT_W-1:0] chunk_size,
    input  logic                              in_valid,
    input  logic [KEY_WIDTH-1:0]              in_key,
    input  logic [TAG_WIDTH-1:0]              in_tag,
    output logic                              out_valid,
    output logic [KEY_WIDTH-1:0]              out_key,
    output logic [TAG_WIDTH-1:0]              out_tag,
    output logic                              out_last
);

    localparam int LANES = sort_lane_pkg::LANES;
    localparam int CW    = sort_lane_pkg::COUNT_W;
    localparam int IW    = sort_lane_pkg::LANE_IDX_W;

    logic                 lane_pad [LANES];
    logic [KEY_WIDTH-1:0] lane_key [LANES];
    logic [TAG_WIDTH-1:0] lane_tag [LANES];
    logic [CW-1:0]        chunk_count;
    logic                 load_done;

    logic [KEY_WIDTH-1:0] sorted_key [LANES];
    logic [TAG_WIDTH-1:0] sorted_tag [LANES];
    logic [CW-1:0]        sorted_count;
    logic                 sorted_valid;

    logic                 cnt_clear;
    logic                 cnt_step;
    logic [CW-1:0]        cnt_limit;
    logic [IW-1:0]        lane_idx;
    logic                 at_last;

    chunk_loader #(
        .KEY_WIDTH (KEY_WIDTH),
        .TAG_WIDTH (TAG_WIDTH)
    ) u_loader (
        .clock       (clock),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_key      (in_key),
        .in_tag      (in_tag),
        .chunk_size  (chunk_size),
        .lane_pad    (lane_pad),
        .lane_key    (lane_key),
        .lane_tag    (lane_tag),
        .chunk_count (chunk_count),
        .load_done   (load_done)
    );

    // Pads sort to the top lanes and are never sent, so out_pad stays open
    merge_network #(
        .KEY_WIDTH (KEY_WIDTH),
        .TAG_WIDTH (TAG_WIDTH)
    ) u_network (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_pad    (lane_pad),
        .in_key    (lane_key),
        .in_tag    (lane_tag),
        .in_count  (chunk_count),
        .in_valid  (load_done),
        .out_pad   (),
        .out_key   (sorted_key),
        .out_tag   (sorted_tag),
        .out_count (sorted_count),
        .out_valid (sorted_valid)
    );

    lane_counter u_counter (
        .clock   (clock),
        .rst_n   (rst_n),
        .clear   (cnt_clear),
        .step    (cnt_step),
        .limit   (cnt_limit),
        .idx     (lane_idx),
        .at_last (at_last)
    );

    out_serializer_fsm #(
        .KEY_WIDTH (KEY_WIDTH),
        .TAG_WIDTH (TAG_WIDTH)
    ) u_serializer (
        .clock        (clock),
        .rst_n        (rst_n),
        .sorted_key   (sorted_key),
        .sorted_tag   (sorted_tag),
        .sorted_count (sorted_count),
        .sorted_valid (sorted_valid),
        .idx          (lane_idx),
        .at_last      (at_last),
        .cnt_clear    (cnt_clear),
        .cnt_step     (cnt_step),
        .cnt_limit    (cnt_limit),
        .out_valid    (out_valid),
        .out_key      (out_key),
        .out_tag      (out_tag),
        .out_last     (out_last)
    );

endmodule

// File: hw/sort_ctrl_pkg.sv
//**************************************************************************
// Sort control package
// Serializer state encoding and the legal range of the chunk size.
//**************************************************************************

package sort_ctrl_pkg;

    // Output serializer states
    typedef enum logic [1:0] {
        ser_idle   = 2'd0,
        ser_stream = 2'd1
    } ser_state_e;

    // Smallest chunk that may be requested
    parameter int MIN_CHUNK = 1;

    // A chunk can never be larger than the network
    parameter int MAX_CHUNK = sort_lane_pkg::LANES;

endpackage

// File: hw/sort_lane_pkg.sv
//**************************************************************************
// Sort lane package
// Geometry of the eight-lane Batcher odd-even merge network: lane count,
// pipeline depth and the widths of lane indices and chunk counts.
//**************************************************************************

package sort_lane_pkg;

    // Number of parallel lanes sorted by the network
    parameter int LANES = 8;

    // One register stage per comparator column of the eight-input network
    parameter int STAGES = 6;

    // Width of an index that selects one lane
    parameter int LANE_IDX_W = $clog2(LANES);

    // A chunk count runs from 1 to LANES and needs one bit more than an index
    parameter int COUNT_W = LANE_IDX_W + 1;

endpackage

// File: run_sim.sh
#!/bin/sh
# Build the serial Batcher sorter testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_serial_batcher_sorter \
    -f serial_batcher_sorter.f

output=$(./obj_dir/Vtb_serial_batcher_sorter)
echo "$output"

if echo "$output" | grep -q "All tests passed!"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

// File: serial_batcher_sorter.f
hw/sort_lane_pkg.sv
hw/sort_ctrl_pkg.sv
hw/chunk_loader.sv
hw/merge_network.sv
hw/lane_counter.sv
hw/out_serializer_fsm.sv
hw/serial_batcher_sorter.sv
verif/tb_serial_batcher_sorter.sv

// File: verif/tb_serial_batcher_sorter.sv
//**************************************************************************
// Serial Batcher sorter testbench
// Sends back-to-back chunks of every legal size with pseudo-random keys
// and tags, then one chunk set with equal keys. Assertions check timing,
// ordering, chunk framing and that every key keeps its tag.
//**************************************************************************

module tb_serial_batcher_sorter;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int KEY_WIDTH       = 16;
    localparam int TAG_WIDTH       = 8;
    localparam int PAIR_W          = KEY_WIDTH + TAG_WIDTH;
    localparam int CW              = sort_lane_pkg::COUNT_W;
    localparam int MAX_CHUNK       = sort_ctrl_pkg::MAX_CHUNK;
    localparam int CLOCK_PERIOD    = 100;
    localparam int RESET_CYCLES    = 8;
    localparam int SEED            = 48179;
    localparam int CHUNKS_PER_TEST = 4;
    // out_valid rises after edge k+7 and is first sampled at edge k+8
    localparam int LATENCY         = 7;
    localparam int FIRST_OUT       = LATENCY + 1;
    localparam int NUM_TESTS       = MAX_CHUNK - sort_ctrl_pkg::MIN_CHUNK + 2;
    localparam int TOTAL_ELEMS     = CHUNKS_PER_TEST *
                                     (MAX_CHUNK * (MAX_CHUNK + 1) / 2 + MAX_CHUNK);
    localparam int TEST_OVERHEAD   = LATENCY + MAX_CHUNK + 4;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + TOTAL_ELEMS + NUM_TESTS * TEST_OVERHEAD + 20;

    typedef logic [PAIR_W-1:0] pair_t;

    logic                 clock;
    logic                 rst_n;
    logic [CW-1:0]        chunk_size;
    logic                 in_valid;
    logic [KEY_WIDTH-1:0] in_key;
    logic [TAG_WIDTH-1:0] in_tag;
    logic                 out_valid;
    logic [KEY_WIDTH-1:0] out_key;
    logic [TAG_WIDTH-1:0] out_tag;
    logic                 out_last;

    // Reference chunks, each stored sorted by key and then by tag
    pair_t                exp_pairs [$];
    int                   exp_size [$];
    int                   exp_edge [$];
    pair_t                rx_q [$];
    logic [KEY_WIDTH-1:0] last_key;
    logic [31:0]          rng_state;
    int                   edge_num = 0;
    int                   errors = 0;
    int                   tests_run = 0;
    int                   tests_passed = 0;
    int                   chunks_checked = 0;

    serial_batcher_sorter #(
        .KEY_WIDTH (KEY_WIDTH),
        .TAG_WIDTH (TAG_WIDTH)
    ) UUT (
        .clock      (clock),
        .rst_n      (rst_n),
        .chunk_size (chunk_size),
        .in_valid   (in_valid),
        .in_key     (in_key),
        .in_tag     (in_tag),
        .out_valid  (out_valid),
        .out_key    (out_key),
        .out_tag    (out_tag),
        .out_last   (out_last)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic value_error(input string name, input longint expected, input longint actual);
        $display("Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
        errors++;
    endtask

    task automatic behavior_error(input string what);
        $display("Check failed at %0t ns: %s", $time, what);
        errors++;
    endtask

    // Compare the received chunk with its reference as two sorted multisets
    task automatic close_chunk();
        pair_t expected;
        rx_q.sort();
        foreach (rx_q[i]) begin
            expected = exp_pairs.pop_front();
            assert (rx_q[i] == expected)
                else value_error("{out_key,out_tag}", expected, rx_q[i]);
        end
        for (int i = rx_q.size(); i < exp_size[0]; i++) begin
            expected = exp_pairs.pop_front();
        end
        exp_size.pop_front();
        exp_edge.pop_front();
        rx_q.delete();
        chunks_checked++;
    endtask

    always @(posedge clock) begin
        edge_num = edge_num + 1;
        if (rst_n) begin
            assert (out_valid || !out_last) else behavior_error("out_last high without out_valid");
            if (rx_q.size() == 0) begin
                if (exp_size.size() == 0) begin
                    assert (!out_valid) else behavior_error("out_valid high with no chunk sent");
                end else if (edge_num < exp_edge[0] + FIRST_OUT) begin
                    assert (!out_valid) else behavior_error("chunk output started early");
                end else if (edge_num == exp_edge[0] + FIRST_OUT) begin
                    assert (out_valid) else value_error("out_valid", 1, out_valid);
                end
            end else begin
                // A gap inside a chunk
                assert (out_valid) else value_error("out_valid", 1, out_valid);
            end
            if (out_valid && exp_size.size() != 0) begin
                if (rx_q.size() != 0) begin
                    assert (out_key >= last_key)
                        else value_error("out_key minimum", last_key, out_key);
                end
                last_key = out_key;
                rx_q.push_back({out_key, out_tag});
                assert (out_last == (rx_q.size() == exp_size[0]))
                    else value_error("out_last", rx_q.size() == exp_size[0], out_last);
                if (out_last || rx_q.size() == exp_size[0]) begin
                    close_chunk();
                end
            end
        end
    end

    task automatic send_chunk(input int size, input bit same_key);
        pair_t chunk_q [$];
        for (int i = 0; i < size; i++) begin
            @(negedge clock);
            rng_state = xorshift32(rng_state);
            in_valid  = 1'b1;
            // Sixteen distinct keys spread over the word so that ties are common
            in_key    = same_key ? 16'h5a3c : {rng_state[31:30], 12'h000, rng_state[1:0]};
            in_tag    = rng_state[15:8];
            chunk_q.push_back({in_key, in_tag});
        end
        chunk_q.sort();
        foreach (chunk_q[i]) begin
            exp_pairs.push_back(chunk_q[i]);
        end
        exp_size.push_back(size);
        exp_edge.push_back(edge_num + 1);
    endtask

    task automatic run_test(input string name, input int size, input bit same_key);
        int errors_before;
        errors_before = errors;
        @(negedge clock);
        chunk_size = CW'(size);
        for (int c = 0; c < CHUNKS_PER_TEST; c++) begin
            send_chunk(size, same_key);
        end
        @(negedge clock);
        in_valid = 1'b0;
        while (exp_size.size() != 0) begin
            @(negedge clock);
        end
        tests_run++;
        if (errors == errors_before) begin
            tests_passed++;
            $display("Test %0d (%s): pass", tests_run, name);
        end else begin
            $display("Test %0d (%s): fail with %0d errors", tests_run, name,
                     errors - errors_before);
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_key     = '0;
        in_tag     = '0;
        chunk_size = CW'(sort_ctrl_pkg::MIN_CHUNK);
        rng_state  = SEED;
        repeat (RESET_CYCLES) @(negedge clock);
        rst_n = 1'b1;
        for (int s = sort_ctrl_pkg::MIN_CHUNK; s <= MAX_CHUNK; s++) begin
            run_test($sformatf("random keys, chunk size %0d", s), s, 1'b0);
        end
        run_test($sformatf("equal keys, chunk size %0d", MAX_CHUNK), MAX_CHUNK, 1'b1);
        $display("Tests run %0d, passed %0d, failed %0d, chunks checked %0d, check errors %0d",
                 tests_run, tests_passed, tests_run - tests_passed, chunks_checked, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("Watchdog expired after %0d cycles with %0d chunks still outstanding",
                 WATCHDOG_CYCLES, exp_size.size());
        $display("Test failures found");
        $finish;
    end

endmodule
